/* include/fetch_cfg.svh */
// build-time constants for the fetch front end; IMEM_BASE must stay 8-byte aligned and IMEM_LAT >= 1
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// ==================================================
// program counter
// ==================================================

// first address fetched after reset
`define FETCH_RESET_PC 64'h0000_0000_8000_0000

// width of pc and fetch bus addresses
`define FETCH_AW 64

// ==================================================
// instruction memory
// ==================================================

// byte address of word 0
`define IMEM_BASE `FETCH_RESET_PC

// number of 64-bit words, 2 KB in total
`define IMEM_WORDS 256

// cycles from accepted request to rvalid
`define IMEM_LAT 3

`endif

/* design/fetch_pkg.sv */
// shared fetch types; rresp_t keeps the 2-bit AXI response encoding, only OKAY and SLVERR are produced
`default_nettype none

package fetch_pkg;

  // ==================================================
  // fetch unit read machine
  // ==================================================

  // idle issues arvalid, wait holds rready until the response
  typedef enum logic {
    FS_IDLE = 1'b0,
    FS_WAIT = 1'b1
  } fetch_state_t;

  // ==================================================
  // read response codes
  // ==================================================

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_SLVERR = 2'd2
  } rresp_t;

endpackage

`default_nettype wire

/* design/fetch_unit.sv */
// single-outstanding fetch unit; rst_n is active high, redirects are ignored while stall_i is high
`default_nettype none

`include "fetch_cfg.svh"

module fetch_unit (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     redirect_i,
  input  wire [`FETCH_AW-1:0]     redirect_pc_i,
  input  wire                     stall_i,
  input  wire                     arready_i,
  input  wire                     rvalid_i,
  input  wire [63:0]              rdata_i,
  input  wire fetch_pkg::rresp_t  rresp_i,
  output logic                    arvalid_o,
  output logic [`FETCH_AW-1:0]    araddr_o,
  output logic                    rready_o,
  output logic                    if_valid_o,
  output logic [`FETCH_AW-1:0]    if_pc_o,
  output logic [31:0]             if_inst_o,
  output logic                    if_fault_o
);

  fetch_pkg::fetch_state_t state_q;
  fetch_pkg::fetch_state_t state_d;

  logic                 arvalid_q;
  logic                 rready_q;
  logic                 discard_q;
  logic [`FETCH_AW-1:0] pc_q;

  logic redirect_acc;
  logic fetch_done;
  logic fetch_keep;

  // a redirect only counts when later stages are moving
  assign redirect_acc = redirect_i & ~stall_i;

  // stall holds the response in the memory
  assign rready_o   = rready_q & ~stall_i;
  assign fetch_done = rready_q & rvalid_i & ~stall_i;

  // response in flight at a redirect is dropped
  assign fetch_keep = fetch_done & ~discard_q & ~redirect_acc;

  // ==================================================
  // read request machine
  // ==================================================

  always_comb begin
    state_d = state_q;
    case (state_q)
      fetch_pkg::FS_IDLE: begin
        if (arvalid_q && arready_i) begin
          state_d = fetch_pkg::FS_WAIT;
        end
      end
      fetch_pkg::FS_WAIT: begin
        if (fetch_done) begin
          state_d = fetch_pkg::FS_IDLE;
        end
      end
      default: state_d = fetch_pkg::FS_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q   <= fetch_pkg::FS_IDLE;
      arvalid_q <= 1'b0;
      rready_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == fetch_pkg::FS_IDLE) begin
        if (state_d == fetch_pkg::FS_WAIT) begin
          arvalid_q <= 1'b0;
          rready_q  <= 1'b1;
        end else begin
          arvalid_q <= 1'b1;
        end
      end else if (state_d == fetch_pkg::FS_IDLE) begin
        // one idle cycle with arvalid low before the next request
        rready_q <= 1'b0;
      end
    end
  end

  // marks the outstanding response as stale
  always_ff @(posedge clk) begin
    if (rst_n) begin
      discard_q <= 1'b0;
    end else if (fetch_done) begin
      discard_q <= 1'b0;
    end else if (redirect_acc && state_q == fetch_pkg::FS_WAIT) begin
      discard_q <= 1'b1;
    end
  end

  // ==================================================
  // program counter
  // ==================================================

  always_ff @(posedge clk) begin
    if (rst_n) begin
      pc_q <= `FETCH_RESET_PC;
    end else if (redirect_acc) begin
      pc_q <= redirect_pc_i;
    end else if (fetch_keep) begin
      pc_q <= pc_q + `FETCH_AW'(4);
    end
  end

  // redirect target goes straight onto the bus when idle
  assign arvalid_o = arvalid_q;
  assign araddr_o  = (redirect_acc && state_q == fetch_pkg::FS_IDLE) ? redirect_pc_i : pc_q;

  // ==================================================
  // instruction select
  // ==================================================

  assign if_valid_o = fetch_keep;
  assign if_pc_o    = pc_q;
  assign if_inst_o  = pc_q[2] ? rdata_i[63:32] : rdata_i[31:0];
  assign if_fault_o = (rresp_i == fetch_pkg::RESP_SLVERR);

endmodule

`default_nettype wire

/* design/imem_axi_rd.sv */
// instruction memory with one read in flight; rvalid comes IMEM_LAT cycles after the accepting edge
`default_nettype none

`include "fetch_cfg.svh"

module imem_axi_rd (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     prog_we_i,
  input  wire [7:0]               prog_addr_i,
  input  wire [63:0]              prog_data_i,
  input  wire                     arvalid_i,
  input  wire [`FETCH_AW-1:0]     araddr_i,
  input  wire                     rready_i,
  output logic                    arready_o,
  output logic                    rvalid_o,
  output logic [63:0]             rdata_o,
  output fetch_pkg::rresp_t       rresp_o
);

  localparam int IDX_W = $clog2(`IMEM_WORDS);
  localparam int CNT_W = $clog2(`IMEM_LAT + 1);

  // memory span in bytes
  localparam logic [`FETCH_AW-1:0] SPAN = `FETCH_AW'(`IMEM_WORDS) * `FETCH_AW'(8);

  logic [63:0] mem [`IMEM_WORDS];

  // request tracking
  logic             pending_q;
  logic [CNT_W-1:0] cnt_q;
  logic             rvalid_q;

  // latched request
  logic [IDX_W-1:0] idx_q;
  logic             hit_q;

  // response payload
  logic [63:0]       rdata_q;
  fetch_pkg::rresp_t rresp_q;

  logic [`FETCH_AW-1:0] offset;
  logic                 in_range;
  logic                 ar_fire;
  logic                 r_fire;
  logic                 load_resp;

  // ==================================================
  // address decode
  // ==================================================

  assign offset   = araddr_i - `IMEM_BASE;
  assign in_range = (araddr_i >= `IMEM_BASE) && (offset < SPAN);

  assign arready_o = ~pending_q;
  assign ar_fire   = arvalid_i & ~pending_q;
  assign r_fire    = rvalid_q & rready_i;

  // last countdown step loads the response
  assign load_resp = pending_q && (cnt_q == CNT_W'(1));

  // ==================================================
  // storage
  // ==================================================

  // preload port from the testbench
  always_ff @(posedge clk) begin
    if (prog_we_i) begin
      mem[prog_addr_i] <= prog_data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (ar_fire) begin
      idx_q <= offset[IDX_W+2:3];
      hit_q <= in_range;
    end
  end

  // ==================================================
  // latency counter and response
  // ==================================================

  always_ff @(posedge clk) begin
    if (rst_n) begin
      pending_q <= 1'b0;
      cnt_q     <= '0;
      rvalid_q  <= 1'b0;
    end else begin
      if (ar_fire) begin
        pending_q <= 1'b1;
        cnt_q     <= CNT_W'(`IMEM_LAT);
      end else if (cnt_q != '0) begin
        cnt_q <= cnt_q - CNT_W'(1);
      end

      if (load_resp) begin
        rvalid_q <= 1'b1;
      end else if (r_fire) begin
        // response taken, accept a new request next cycle
        rvalid_q  <= 1'b0;
        pending_q <= 1'b0;
      end
    end
  end

  // held steady until the response completes
  always_ff @(posedge clk) begin
    if (load_resp) begin
      if (hit_q) begin
        rdata_q <= mem[idx_q];
        rresp_q <= fetch_pkg::RESP_OKAY;
      end else begin
        rdata_q <= '0;
        rresp_q <= fetch_pkg::RESP_SLVERR;
      end
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;
  assign rresp_o  = rresp_q;

endmodule

`default_nettype wire

/* design/if_id_reg.sv */
// IF/ID stage register; flush beats stall, and valid drops when no new instruction arrives
`default_nettype none

`include "fetch_cfg.svh"

module if_id_reg (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  stall_i,
  input  wire                  flush_i,
  input  wire                  in_valid_i,
  input  wire [`FETCH_AW-1:0]  in_pc_i,
  input  wire [31:0]           in_inst_i,
  input  wire                  in_fault_i,
  output logic                 id_valid_o,
  output logic [`FETCH_AW-1:0] id_pc_o,
  output logic [31:0]          id_inst_o,
  output logic                 id_fault_o
);

  // valid flag
  always_ff @(posedge clk) begin
    if (rst_n) begin
      id_valid_o <= 1'b0;
    end else if (flush_i) begin
      id_valid_o <= 1'b0;
    end else if (!stall_i) begin
      id_valid_o <= in_valid_i;
    end
  end

  // payload only moves on a new instruction
  always_ff @(posedge clk) begin
    if (!flush_i && !stall_i && in_valid_i) begin
      id_pc_o    <= in_pc_i;
      id_inst_o  <= in_inst_i;
      id_fault_o <= in_fault_i;
    end
  end

endmodule

`default_nettype wire

/* design/fetch_top.sv */
// fetch front end top; a prog_* write lands on the next edge and must come before the fetch of that word
`default_nettype none

`include "fetch_cfg.svh"

module fetch_top (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire                 redirect_i,
  input  wire [`FETCH_AW-1:0] redirect_pc_i,
  input  wire                 stall_i,
  input  wire                 prog_we_i,
  input  wire [7:0]           prog_addr_i,
  input  wire [63:0]          prog_data_i,
  output wire                 id_valid_o,
  output wire [`FETCH_AW-1:0] id_pc_o,
  output wire [31:0]          id_inst_o,
  output wire                 id_fault_o,
  output wire                 fetch_commit_o
);

  // read channel
  wire                 arvalid;
  wire                 arready;
  wire [`FETCH_AW-1:0] araddr;
  wire                 rvalid;
  wire                 rready;
  wire [63:0]          rdata;
  fetch_pkg::rresp_t   rresp;

  // fetch to IF/ID
  wire                 if_valid;
  wire [`FETCH_AW-1:0] if_pc;
  wire [31:0]          if_inst;
  wire                 if_fault;

  fetch_unit u_fetch (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .stall_i       (stall_i),
    .arready_i     (arready),
    .rvalid_i      (rvalid),
    .rdata_i       (rdata),
    .rresp_i       (rresp),
    .arvalid_o     (arvalid),
    .araddr_o      (araddr),
    .rready_o      (rready),
    .if_valid_o    (if_valid),
    .if_pc_o       (if_pc),
    .if_inst_o     (if_inst),
    .if_fault_o    (if_fault)
  );

  imem_axi_rd u_imem (
    .clk         (clk),
    .rst_n       (rst_n),
    .prog_we_i   (prog_we_i),
    .prog_addr_i (prog_addr_i),
    .prog_data_i (prog_data_i),
    .arvalid_i   (arvalid),
    .araddr_i    (araddr),
    .rready_i    (rready),
    .arready_o   (arready),
    .rvalid_o    (rvalid),
    .rdata_o     (rdata),
    .rresp_o     (rresp)
  );

  // redirect also squashes whatever sits in IF/ID
  if_id_reg u_if_id (
    .clk        (clk),
    .rst_n      (rst_n),
    .stall_i    (stall_i),
    .flush_i    (redirect_i),
    .in_valid_i (if_valid),
    .in_pc_i    (if_pc),
    .in_inst_i  (if_inst),
    .in_fault_i (if_fault),
    .id_valid_o (id_valid_o),
    .id_pc_o    (id_pc_o),
    .id_inst_o  (id_inst_o),
    .id_fault_o (id_fault_o)
  );

  assign fetch_commit_o = if_valid;

endmodule

`default_nettype wire

/* testbench/tb_clk_gen.sv */
// 20 ns clock and active-high rst_n held for 8 rising edges, released on a falling edge
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int HALF_NS    = 10;
  localparam int RST_CYCLES = 8;

  initial begin
    clk_o = 1'b0;
    forever #HALF_NS clk_o = ~clk_o;
  end

  // reset is active high
  initial begin
    rst_n_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b0;
  end

endmodule

`default_nettype wire

/* testbench/fetch_checker.sv */
// watches the fetch top ports; redirects during stall are not modelled and must not be driven
`default_nettype none

`include "fetch_cfg.svh"

module fetch_checker (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire                 redirect_i,
  input  wire [`FETCH_AW-1:0] redirect_pc_i,
  input  wire                 stall_i,
  input  wire                 id_valid_i,
  input  wire [`FETCH_AW-1:0] id_pc_i,
  input  wire [31:0]          id_inst_i,
  input  wire                 id_fault_i,
  input  wire                 fetch_commit_i,
  input  logic [63:0]         image_i [`IMEM_WORDS],
  output int                  commits_o,
  output int                  beats_o,
  output int                  errors_o
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int IDX_W = $clog2(`IMEM_WORDS);
  localparam logic [`FETCH_AW-1:0] SPAN = `FETCH_AW'(`IMEM_WORDS) * `FETCH_AW'(8);

  int commit_cnt = 0;
  int beat_cnt   = 0;
  int err_cnt    = 0;

  // pc of each committed fetch, oldest first
  logic [`FETCH_AW-1:0] expected [$];
  logic [`FETCH_AW-1:0] pc_pred = `FETCH_RESET_PC;

  // edges since the last commit, clean while no stall or redirect came in between
  int   gap_cnt   = 0;
  logic gap_clean = 1'b0;

  // previous-edge samples
  logic                 rst_q      = 1'b0;
  logic                 stall_q    = 1'b0;
  logic                 redirect_q = 1'b0;
  logic                 commit_q   = 1'b0;
  logic                 hold_valid;
  logic [`FETCH_AW-1:0] hold_pc;
  logic [31:0]          hold_inst;
  logic                 hold_fault;

  assign commits_o = commit_cnt;
  assign beats_o   = beat_cnt;
  assign errors_o  = err_cnt;

  // ==================================================
  // reference model
  // ==================================================

  // half word picked by bit 2, SLVERR with zero outside the memory
  function automatic logic [31:0] ref_fetch(input logic [`FETCH_AW-1:0] addr,
                                            output fetch_pkg::rresp_t resp);
    logic [`FETCH_AW-1:0] off;
    logic [63:0]          word;
    off = addr - `IMEM_BASE;
    if (addr < `IMEM_BASE || off >= SPAN) begin
      resp = fetch_pkg::RESP_SLVERR;
      return 32'h0;
    end
    word = image_i[off[IDX_W+2:3]];
    resp = fetch_pkg::RESP_OKAY;
    return addr[2] ? word[63:32] : word[31:0];
  endfunction

  task automatic check_value(input string sig, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
    if (act_v !== exp_v) begin
      $display("ERROR t=%0d ns %s expected %h got %h", $time, sig, exp_v, act_v);
      err_cnt++;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("t=%0d ns failure: %s", $time, msg);
    err_cnt++;
  endtask

  // ==================================================
  // compare on every rising edge
  // ==================================================

  always @(posedge clk) begin : compare
    logic [`FETCH_AW-1:0] exp_pc;
    logic [31:0]          exp_inst;
    fetch_pkg::rresp_t    exp_resp;

    if (rst_n) begin
      pc_pred = `FETCH_RESET_PC;
      expected.delete();
      gap_cnt   = 0;
      gap_clean = 1'b0;
    end else begin
      // IF/ID held through the previous stalled edge
      if (stall_q && !redirect_q && !rst_q) begin
        check_value("id_valid_o", 64'(hold_valid), 64'(id_valid_i));
        check_value("id_pc_o", hold_pc, id_pc_i);
        check_value("id_inst_o", 64'(hold_inst), 64'(id_inst_i));
        check_value("id_fault_o", 64'(hold_fault), 64'(id_fault_i));
      end

      // a commit shows up in IF/ID one cycle later and a redirect clears it
      if (!rst_q && (!stall_q || redirect_q)) begin
        check_value("id_valid_o", 64'(commit_q && !redirect_q), 64'(id_valid_i));
      end

      // beat taken by decode
      if (id_valid_i && !stall_i) begin
        if (expected.size() == 0) begin
          report_failure("instruction reached IF/ID without a fetch commit behind it");
        end else begin
          exp_pc   = expected.pop_front();
          exp_inst = ref_fetch(exp_pc, exp_resp);
          check_value("id_pc_o", exp_pc, id_pc_i);
          check_value("id_inst_o", 64'(exp_inst), 64'(id_inst_i));
          check_value("id_fault_o", 64'(exp_resp == fetch_pkg::RESP_SLVERR),
                      64'(id_fault_i));
          beat_cnt++;
        end
      end

      gap_cnt++;
      if (stall_i || redirect_i) begin
        gap_clean = 1'b0;
      end

      if (fetch_commit_i) begin
        if (stall_i) begin
          check_value("fetch_commit_o", 64'(0), 64'(fetch_commit_i));
        end
        // undisturbed fetches complete every IMEM_LAT+3 cycles
        if (gap_clean) begin
          check_value("fetch_commit_o spacing", 64'(`IMEM_LAT + 3), 64'(gap_cnt));
        end
        gap_cnt   = 0;
        gap_clean = 1'b1;
        expected.push_back(pc_pred);
        pc_pred = pc_pred + `FETCH_AW'(4);
        commit_cnt++;
      end

      if (redirect_i && !stall_i) begin
        pc_pred = redirect_pc_i;
      end
    end

    // reset cycles and the first cycle after
    if (rst_q) begin
      check_value("id_valid_o", 64'(0), 64'(id_valid_i));
      check_value("fetch_commit_o", 64'(0), 64'(fetch_commit_i));
    end

    rst_q      = rst_n;
    stall_q    = stall_i;
    redirect_q = redirect_i;
    commit_q   = fetch_commit_i;
    hold_valid = id_valid_i;
    hold_pc    = id_pc_i;
    hold_inst  = id_inst_i;
    hold_fault = id_fault_i;
  end

endmodule

`default_nettype wire

/* testbench/fetch_tb.sv */
// fetch front end testbench; needs timing support, preload runs ahead of fetch from reset on
`default_nettype none

`include "fetch_cfg.svh"

module fetch_tb;
  timeunit 1ns;
  timeprecision 1ps;

  // test lengths in fetch slots
  localparam int N_SEQ     = 40;
  localparam int N_REDIR   = 10;
  localparam int REDIR_RUN = 3;
  localparam int N_STALL   = 40;
  localparam int N_FAULT   = 4;
  localparam int LEN_REDIR = N_REDIR * (REDIR_RUN + 1);
  // stalls roughly double each fetch
  localparam int LEN_STALL = 2 * N_STALL;
  localparam int LEN_TOTAL = N_SEQ + LEN_REDIR + LEN_STALL + N_FAULT + 2;
  localparam longint WATCHDOG_NS = 64'(2 * LEN_TOTAL * (`IMEM_LAT + 3) * 20);

  wire clk;
  wire rst_n;

  logic                 redirect;
  logic [`FETCH_AW-1:0] redirect_pc;
  logic                 stall;
  logic                 prog_we;
  logic [7:0]           prog_addr;
  logic [63:0]          prog_data;

  wire                  id_valid;
  wire [`FETCH_AW-1:0]  id_pc;
  wire [31:0]           id_inst;
  wire                  id_fault;
  wire                  fetch_commit;

  int commits;
  int beats;
  int errors;
  int ntests = 0;

  logic [63:0] image [`IMEM_WORDS];
  integer      seed;
  logic        preload_done = 1'b0;

  tb_clk_gen u_clk (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  fetch_top dut0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .redirect_i     (redirect),
    .redirect_pc_i  (redirect_pc),
    .stall_i        (stall),
    .prog_we_i      (prog_we),
    .prog_addr_i    (prog_addr),
    .prog_data_i    (prog_data),
    .id_valid_o     (id_valid),
    .id_pc_o        (id_pc),
    .id_inst_o      (id_inst),
    .id_fault_o     (id_fault),
    .fetch_commit_o (fetch_commit)
  );

  fetch_checker u_check (
    .clk            (clk),
    .rst_n          (rst_n),
    .redirect_i     (redirect),
    .redirect_pc_i  (redirect_pc),
    .stall_i        (stall),
    .id_valid_i     (id_valid),
    .id_pc_i        (id_pc),
    .id_inst_i      (id_inst),
    .id_fault_i     (id_fault),
    .fetch_commit_i (fetch_commit),
    .image_i        (image),
    .commits_o      (commits),
    .beats_o        (beats),
    .errors_o       (errors)
  );

  // ==================================================
  // stimulus helpers
  // ==================================================

  // one word per cycle, far ahead of the sequential fetch stream
  task automatic preload();
    int i;
    for (i = 0; i < `IMEM_WORDS; i++) begin
      @(negedge clk);
      prog_we   = 1'b1;
      prog_addr = 8'(i);
      prog_data = image[i];
    end
    @(negedge clk);
    prog_we      = 1'b0;
    preload_done = 1'b1;
  endtask

  task automatic wait_commits(input int n);
    int target;
    target = commits + n;
    while (commits < target) begin
      @(negedge clk);
    end
  endtask

  task automatic pulse_redirect(input logic [`FETCH_AW-1:0] target);
    @(negedge clk);
    redirect    = 1'b1;
    redirect_pc = target;
    @(negedge clk);
    redirect = 1'b0;
  endtask

  task automatic report_test(input string name, input int e0, input int b0);
    ntests++;
    $display("test %-12s %0d beats, %0d errors", name, beats - b0, errors - e0);
  endtask

  // ==================================================
  // test sequence
  // ==================================================

  task automatic run_tests();
    int e0;
    int b0;
    int n;
    int d;
    int rnd;

    @(negedge rst_n);
    @(negedge clk);
    report_test("reset", 0, 0);

    e0 = errors;
    b0 = beats;
    wait_commits(N_SEQ);
    report_test("sequential", e0, b0);

    // random targets land in idle and in the response wait
    wait (preload_done);
    e0 = errors;
    b0 = beats;
    for (n = 0; n < N_REDIR; n++) begin
      wait_commits(REDIR_RUN);
      d = int'($unsigned($random(seed)) % 5);
      repeat (d) @(negedge clk);
      rnd = $random(seed);
      pulse_redirect(`IMEM_BASE +
                     `FETCH_AW'($unsigned(rnd) % (`IMEM_WORDS * 2)) * `FETCH_AW'(4));
    end
    wait_commits(REDIR_RUN);
    report_test("redirect", e0, b0);

    e0 = errors;
    b0 = beats;
    n  = commits + N_STALL;
    while (commits < n) begin
      @(negedge clk);
      stall = ($unsigned($random(seed)) % 3) == 0;
    end
    stall = 1'b0;
    wait_commits(2);
    report_test("stall", e0, b0);

    // just past the last word
    e0 = errors;
    b0 = beats;
    pulse_redirect(`IMEM_BASE + `FETCH_AW'(`IMEM_WORDS * 8) + `FETCH_AW'(16));
    wait_commits(N_FAULT);
    repeat (4) @(negedge clk);
    report_test("out of range", e0, b0);
  endtask

  initial begin
    redirect    = 1'b0;
    redirect_pc = '0;
    stall       = 1'b0;
    prog_we     = 1'b0;
    prog_addr   = '0;
    prog_data   = '0;
    seed        = 32'h11b;
    for (int i = 0; i < `IMEM_WORDS; i++) begin
      image[i] = {$random(seed), $random(seed)};
    end

    fork
      preload();
      run_tests();
    join

    $display("summary: %0d tests, %0d commits, %0d beats checked, %0d errors",
             ntests, commits, beats, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("timeout: tests still running after %0d ns", WATCHDOG_NS);
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+include
design/fetch_pkg.sv
design/fetch_unit.sv
design/imem_axi_rd.sv
design/if_id_reg.sv
design/fetch_top.sv
testbench/tb_clk_gen.sv
testbench/fetch_checker.sv
testbench/fetch_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module fetch_tb -o fetch_sim

out=$(./obj_dir/fetch_sim)
echo "$out"

if echo "$out" | grep -qxF '** PASS **'; then
  exit 0
else
  exit 1
fi
